/* Bender.yml */
package:
  name: spi_periph

sources:
  - src/spi_pkg.sv
  - src/spi_sclk_gen.sv
  - src/spi_xcvr.sv
  - src/spi_master.sv
  - src/spi_periph_top.sv
  - target: test
    files:
      - testbench/spi_slave_model.sv
      - testbench/tb_spi_periph.sv

/* filelist.f */
src/spi_pkg.sv
src/spi_sclk_gen.sv
src/spi_xcvr.sv
src/spi_master.sv
src/spi_periph_top.sv
testbench/spi_slave_model.sv
testbench/tb_spi_periph.sv

/* src/spi_master.sv */
module spi_master #(
  parameter int clk_freq  = 50_000_000,
  parameter int sclk_freq = 6_250_000
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              miso,
  output logic              mosi,
  output logic              sclk,
  output logic [7:0]        selects,
  output logic [1:0]        itd,
  input  logic              wp_n,
  input  logic [3:0]        be,
  input  logic [31:0]       data_in,
  output logic [31:0]       data_out,
  input  logic              read,
  input  logic              write,
  input  spi_pkg::spi_reg_e address
);

  import spi_pkg::*;

  spi_state_e  state;
  logic [7:0]  conf;
  logic [7:0]  tx_byte;
  logic [7:0]  rx_byte;
  logic [7:0]  xcvr_rx;
  logic        start;
  logic        done;
  logic        data_wr;
  logic        ctrl_wr;
  logic        data_rd;
  logic        tx_load;
  logic        rx_load;
  logic [31:0] ctrl_word;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign data_wr = write && (address == REG_DATA);
  assign ctrl_wr = write && (address == REG_CTRL);
  assign data_rd = read && (address == REG_DATA);
  assign tx_load = data_wr && be[0] && (state == ST_IDLE);  // Writes outside idle drop out here
  assign rx_load = done && (state == ST_BUSY);

  // Status flags sit in the low bits of the control word
  assign ctrl_word = {selects, conf, 11'h000, itd, ~wp_n,
                      (state != ST_BUSY), (state == ST_COMPLETE)};

  always_comb begin
    data_out = 32'h0000_0000;  // Bus is zero when not being read
    if (read) begin
      case (address)
        REG_DATA: data_out = {24'h00_0000, rx_byte};
        REG_CTRL: data_out = ctrl_word;
        default:  data_out = 32'h0000_0000;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control registers and transfer FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      selects <= SELECTS_RESET;
      conf    <= 8'h00;
      itd     <= 2'b00;
      start   <= 1'b0;
      state   <= ST_IDLE;
    end else begin
      start <= 1'b0;
      if (ctrl_wr) begin
        if (be[3]) selects <= data_in[31:24];
        if (be[2]) conf <= data_in[23:16];
        if (be[0]) itd <= data_in[1:0];
      end
      case (state)
        ST_IDLE: begin
          if (tx_load) begin
            state <= ST_BUSY;
            start <= 1'b1;  // Transceiver sees the byte register one cycle later
          end
        end
        ST_BUSY: begin
          if (done) state <= ST_COMPLETE;
        end
        ST_COMPLETE: begin
          if (data_rd) state <= ST_RELEASE;  // Reading the byte clears receive-ready
        end
        ST_RELEASE: begin
          if (!read && !write) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (tx_load) tx_byte <= data_in[7:0];
    if (rx_load) rx_byte <= xcvr_rx;
  end

  spi_xcvr #(
    .clk_freq  (clk_freq),
    .sclk_freq (sclk_freq)
  ) u_xcvr (
    .clk     (clk),
    .rst_n   (rst_n),
    .conf    (conf),
    .start   (start),
    .tx_byte (tx_byte),
    .rx_byte (xcvr_rx),
    .done    (done),
    .miso    (miso),
    .mosi    (mosi),
    .sclk    (sclk)
  );

  // A done from the transceiver belongs to the byte this FSM started
  a_done_in_busy : assert property (
    @(posedge clk) disable iff (!rst_n)
    done |-> (state == ST_BUSY)
  );

  a_strobes_exclusive : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(read && write)
  );

endmodule

/* src/spi_periph_top.sv */
module spi_periph_top #(
  parameter int clk_freq  = 50_000_000,  // System clock
  parameter int sclk_freq = 6_250_000    // Serial clock, half period of 4 clk cycles
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              miso,
  output logic              mosi,
  output logic              sclk,
  output logic [7:0]        selects,
  output logic [1:0]        itd,
  input  logic              wp_n,
  input  logic [3:0]        be,
  input  logic [31:0]       data_in,
  output logic [31:0]       data_out,
  input  logic              read,
  input  logic              write,
  input  spi_pkg::spi_reg_e address
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // SPI master peripheral
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  spi_master #(
    .clk_freq  (clk_freq),
    .sclk_freq (sclk_freq)
  ) u_master (
    .clk      (clk),
    .rst_n    (rst_n),
    .miso     (miso),
    .mosi     (mosi),
    .sclk     (sclk),
    .selects  (selects),
    .itd      (itd),      // Backlight and data/command lines
    .wp_n     (wp_n),
    .be       (be),
    .data_in  (data_in),
    .data_out (data_out),
    .read     (read),
    .write    (write),
    .address  (address)
  );

endmodule

/* src/spi_pkg.sv */
package spi_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Transfer state of the bus-side register block
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    ST_IDLE     = 2'b00,  // Ready for a new data write
    ST_BUSY     = 2'b01,  // Byte on the wire
    ST_COMPLETE = 2'b10,  // Received byte waiting to be read
    ST_RELEASE  = 2'b11   // Data read seen, back to idle on a quiet bus cycle
  } spi_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register map, one address bit
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic {
    REG_DATA = 1'b0,  // Transmit byte on write, received byte on read
    REG_CTRL = 1'b1   // Selects, config, itd and status flags
  } spi_reg_e;

  // Bit positions inside the config byte
  localparam int CONF_CPHA = 0;  // Clock phase
  localparam int CONF_CPOL = 1;  // Clock idle level

  // Chip selects come out of reset with the low four deasserted high
  localparam logic [7:0] SELECTS_RESET = 8'h0F;

endpackage

/* src/spi_sclk_gen.sv */
module spi_sclk_gen #(
  parameter int clk_freq  = 50_000_000,
  parameter int sclk_freq = 6_250_000
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  input  logic cpol,
  output logic sclk,
  output logic lead_edge,
  output logic trail_edge
);

  // Number of clk cycles per half period of the serial clock
  localparam int half_period = clk_freq / (2 * sclk_freq);
  localparam int cnt_w       = (half_period > 1) ? $clog2(half_period) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(half_period - 1);

  logic [cnt_w-1:0] cnt;
  logic             phase;
  logic             tick;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Half-period counter and phase toggle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign tick = run && (cnt == cnt_last);  // Phase flips on this clk edge

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt   <= '0;
      phase <= 1'b0;
    end else if (!run) begin
      cnt   <= '0;  // Each transfer starts a full half period before the first edge
      phase <= 1'b0;
    end else if (tick) begin
      cnt   <= '0;
      phase <= ~phase;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The strobes mark the clk edge on which sclk changes, so the
  // transceiver acts in step with the pin
  assign lead_edge  = tick && !phase;  // Away from the idle level
  assign trail_edge = tick && phase;   // Back to the idle level

  assign sclk = phase ^ cpol;  // Phase is 0 when idle, so sclk rests at cpol

  // Run only drops on a trailing edge, which leaves sclk at its idle level
  a_idle_at_cpol : assert property (
    @(posedge clk) disable iff (!rst_n)
    !run |-> (sclk == cpol)
  );

endmodule

/* src/spi_xcvr.sv */
module spi_xcvr #(
  parameter int clk_freq  = 50_000_000,
  parameter int sclk_freq = 6_250_000
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] conf,
  input  logic       start,
  input  logic [7:0] tx_byte,
  output logic [7:0] rx_byte,
  output logic       done,
  input  logic       miso,
  output logic       mosi,
  output logic       sclk
);

  import spi_pkg::*;

  logic       run;
  logic       lead_edge;
  logic       trail_edge;
  logic       cpha;
  logic       shift_edge;
  logic       sample_edge;
  logic       accept;
  logic [7:0] tx_sr;
  logic [7:0] rx_sr;
  logic [2:0] bit_cnt;
  logic       mosi_q;

  spi_sclk_gen #(
    .clk_freq  (clk_freq),
    .sclk_freq (sclk_freq)
  ) u_sclk_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .cpol       (conf[CONF_CPOL]),
    .sclk       (sclk),
    .lead_edge  (lead_edge),
    .trail_edge (trail_edge)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Mode decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign cpha        = conf[CONF_CPHA];
  assign shift_edge  = cpha ? lead_edge : trail_edge;   // Edge that moves mosi
  assign sample_edge = cpha ? trail_edge : lead_edge;   // Edge that captures miso
  assign accept      = start && !run;                   // A start during a byte is dropped

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bit sequencing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run     <= 1'b0;
      bit_cnt <= '0;
      done    <= 1'b0;
      mosi_q  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (accept) begin
        run     <= 1'b1;
        bit_cnt <= '0;
        if (!cpha) begin
          mosi_q <= tx_byte[7];  // MSB must be on the pin before the first lead edge
        end
      end else if (run) begin
        if (shift_edge) begin
          mosi_q <= tx_sr[7];
        end
        // Every bit ends on a trail edge, the eighth one closes the byte
        if (trail_edge) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            run  <= 1'b0;
            done <= 1'b1;
          end
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Shift registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (accept) begin
      // With cpha 0 the MSB is already on mosi, so it leaves the register now
      tx_sr <= cpha ? tx_byte : {tx_byte[6:0], 1'b0};
    end else if (run) begin
      if (shift_edge) begin
        tx_sr <= {tx_sr[6:0], 1'b0};
      end
      if (sample_edge) begin
        rx_sr <= {rx_sr[6:0], miso};  // MSB first
      end
    end
  end

  assign rx_byte = rx_sr;  // Holds after the last sample until the next start
  assign mosi    = mosi_q;

  // The master only issues start from idle, never over a running byte
  a_start_when_idle : assert property (
    @(posedge clk) disable iff (!rst_n)
    start |-> !run
  );

endmodule

/* testbench/spi_slave_model.sv */
module spi_slave_model (
  input  logic        cs_n,
  input  logic        sclk,
  input  logic        mosi,
  input  logic        cpol,
  input  logic        cpha,
  input  logic [7:0]  reply,
  output logic        miso,
  output logic [7:0]  received,
  output logic [15:0] byte_count
);

  logic [7:0] tx_sr;
  logic [7:0] rx_sr;
  int         bit_cnt;

  initial begin
    miso       = 1'b0;
    received   = 8'h00;
    byte_count = '0;
    tx_sr      = 8'h00;
    rx_sr      = 8'h00;
    bit_cnt    = 0;
  end

  task automatic drive_next_bit();
    miso  = tx_sr[7];  // MSB first
    tx_sr = {tx_sr[6:0], 1'b0};
  endtask

  task automatic capture_bit();
    rx_sr   = {rx_sr[6:0], mosi};
    bit_cnt = bit_cnt + 1;
    if (bit_cnt == 8) begin
      received   = rx_sr;
      byte_count = byte_count + 1'b1;
      bit_cnt    = 0;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Selection and clock edges
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge cs_n) begin
    tx_sr   = reply;
    bit_cnt = 0;
    if (!cpha) drive_next_bit();  // First bit must be there before the first lead edge
  end

  always @(posedge cs_n) bit_cnt = 0;

  always @(sclk) begin
    if (cs_n === 1'b0) begin
      if (sclk !== cpol) begin  // Leading edge, away from the idle level
        if (cpha) drive_next_bit();
        else capture_bit();
      end else begin
        if (cpha) capture_bit();
        else drive_next_bit();
      end
    end
  end

endmodule

/* testbench/tb_spi_periph.sv */
module tb_spi_periph;

  import spi_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        miso;
  logic        mosi;
  logic        sclk;
  logic [7:0]  selects;
  logic [1:0]  itd;
  logic        wp_n;
  logic [3:0]  be;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        read;
  logic        write;
  spi_reg_e    address;
  logic        slave_cpol;
  logic        slave_cpha;
  logic [7:0]  slave_reply;
  logic [7:0]  slave_received;
  logic [15:0] slave_count;
  int          error_count;
  int          check_count;
  logic [31:0] rng_state;

  spi_periph_top dut (
    .clk (clk), .rst_n (rst_n), .miso (miso), .mosi (mosi), .sclk (sclk),
    .selects (selects), .itd (itd), .wp_n (wp_n), .be (be), .data_in (data_in),
    .data_out (data_out), .read (read), .write (write), .address (address)
  );

  spi_slave_model u_slave (
    .cs_n (selects[0]), .sclk (sclk), .mosi (mosi), .cpol (slave_cpol),
    .cpha (slave_cpha), .reply (slave_reply), .miso (miso),
    .received (slave_received), .byte_count (slave_count)
  );

  always #4 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] random_word();
    rng_state = rng_state ^ (rng_state << 13);  // Xorshift32
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] %0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  // Control word as laid out on the bus
  function automatic logic [31:0] expected_ctrl(input logic [7:0] sel, input logic [7:0] cfg,
                                                input logic [1:0] side, input logic tx_ready,
                                                input logic rx_ready);
    return {sel, cfg, 11'h000, side, ~wp_n, tx_ready, rx_ready};
  endfunction

  task automatic bus_write(input spi_reg_e addr, input logic [3:0] enables,
                           input logic [31:0] value);
    address = addr;
    be      = enables;
    data_in = value;
    write   = 1'b1;
    @(posedge clk);
    #1;
    write   = 1'b0;
    be      = 4'h0;
    data_in = '0;
  endtask

  task automatic bus_read(input spi_reg_e addr, output logic [31:0] value);
    address = addr;
    read    = 1'b1;
    #2;
    value = data_out;  // Combinational, settled well ahead of the edge
    @(posedge clk);
    #1;
    read = 1'b0;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic set_mode(input logic cpol, input logic cpha);
    logic [7:0] cfg;
    cfg            = 8'h00;
    cfg[CONF_CPOL] = cpol;
    cfg[CONF_CPHA] = cpha;
    slave_cpol     = cpol;
    slave_cpha     = cpha;
    bus_write(REG_CTRL, 4'b0100, {8'h00, cfg, 16'h0000});
    check_value("sclk_idle", sclk, cpol);
  endtask

  task automatic wait_rx_ready();
    logic [31:0] status;
    int          polls;
    polls     = 0;
    status[0] = 1'b0;
    while (!status[0] && polls < 500) begin
      bus_read(REG_CTRL, status);
      polls++;
      if (status[1]) check_value("sclk_at_cpol", sclk, slave_cpol);
    end
    if (!status[0]) begin
      error_count++;
      $display("Timeout: receive-ready did not rise within %0d polls", polls);
    end
  endtask

  task automatic run_transfer(input logic [7:0] tx, input logic [7:0] reply,
                              output logic [7:0] rx);
    logic [31:0] status;
    logic [31:0] rd;
    logic [15:0] count_before;
    slave_reply  = reply;
    count_before = slave_count;
    bus_write(REG_CTRL, 4'b1000, {8'h0E, 24'h0});  // Select slave 0
    bus_write(REG_DATA, 4'b0001, {24'h0, tx});
    bus_read(REG_CTRL, status);
    check_value("tx_ready_after_write", status[1], 1'b0);
    wait_rx_ready();
    bus_read(REG_DATA, rd);
    rx = rd[7:0];
    check_value("data_out_upper", rd[31:8], 24'h0);
    idle_cycle();
    bus_write(REG_CTRL, 4'b1000, {SELECTS_RESET, 24'h0});
    check_value("slave_byte_count", 16'(slave_count - count_before), 16'd1);
    check_value("slave_rx", slave_received, tx);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_reset_values();
    logic [31:0] rd;
    check_value("sclk", sclk, 1'b0);
    check_value("mosi", mosi, 1'b0);
    check_value("selects", selects, SELECTS_RESET);
    check_value("itd", itd, 2'b00);
    check_value("data_out_idle", data_out, 32'h0);
    bus_read(REG_CTRL, rd);
    check_value("ctrl_reg", rd, expected_ctrl(SELECTS_RESET, 8'h00, 2'b00, 1'b1, 1'b0));
    wp_n = 1'b0;
    bus_read(REG_CTRL, rd);
    check_value("ctrl_reg_wp", rd, expected_ctrl(SELECTS_RESET, 8'h00, 2'b00, 1'b1, 1'b0));
    wp_n = 1'b1;
  endtask

  task automatic test_byte_enables();
    logic [31:0] value;
    logic [31:0] rd;
    logic [7:0]  exp_sel;
    logic [7:0]  exp_cfg;
    logic [1:0]  exp_itd;
    int          en;
    exp_sel = SELECTS_RESET;
    exp_cfg = 8'h00;
    exp_itd = 2'b00;
    for (en = 0; en < 16; en++) begin
      value = random_word();
      bus_write(REG_CTRL, en[3:0], value);
      if (en[3]) exp_sel = value[31:24];
      if (en[2]) exp_cfg = value[23:16];
      if (en[0]) exp_itd = value[1:0];
      bus_read(REG_CTRL, rd);
      check_value("ctrl_reg", rd, expected_ctrl(exp_sel, exp_cfg, exp_itd, 1'b1, 1'b0));
      check_value("selects", selects, exp_sel);
      check_value("itd", itd, exp_itd);
    end
    bus_write(REG_CTRL, 4'b1101, {SELECTS_RESET, 24'h0});  // Back to reset values
  endtask

  task automatic test_all_modes();
    logic [31:0] word;
    logic [7:0]  rx;
    int          m;
    int          n;
    for (m = 0; m < 4; m++) begin
      set_mode(m[1], m[0]);
      for (n = 0; n < 3; n++) begin
        word = random_word();
        run_transfer(word[7:0], word[15:8], rx);
        check_value("rx_byte", rx, word[15:8]);
      end
    end
    set_mode(1'b0, 1'b0);
  endtask

  task automatic test_write_while_busy();
    logic [31:0] rd;
    logic [7:0]  rx;
    logic [15:0] count_before;
    slave_reply  = 8'h96;
    count_before = slave_count;
    bus_write(REG_CTRL, 4'b1000, {8'h0E, 24'h0});
    bus_write(REG_DATA, 4'b0001, {24'h0, 8'h5A});
    idle_cycle();
    bus_write(REG_DATA, 4'b0001, {24'h0, 8'hC3});  // Lands mid-byte
    wait_rx_ready();
    bus_read(REG_DATA, rd);
    check_value("rx_byte", rd, {24'h0, 8'h96});
    idle_cycle();
    bus_write(REG_CTRL, 4'b1000, {SELECTS_RESET, 24'h0});
    check_value("slave_byte_count", 16'(slave_count - count_before), 16'd1);
    check_value("slave_rx", slave_received, 8'h5A);
    run_transfer(8'h21, 8'h7E, rx);
    check_value("rx_byte_next", rx, 8'h7E);
  endtask

  task automatic test_release_and_idle();
    logic [31:0] status;
    logic [31:0] rd;
    logic [7:0]  rx;
    slave_reply = 8'hE7;
    bus_write(REG_CTRL, 4'b1000, {8'h0E, 24'h0});
    bus_write(REG_DATA, 4'b0001, {24'h0, 8'h42});
    wait_rx_ready();
    bus_read(REG_DATA, rd);
    check_value("rx_byte", rd, {24'h0, 8'hE7});
    bus_read(REG_CTRL, status);
    check_value("rx_ready_after_read", status[0], 1'b0);
    idle_cycle();
    bus_read(REG_CTRL, status);
    check_value("tx_ready_after_idle", status[1], 1'b1);
    bus_write(REG_CTRL, 4'b1000, {SELECTS_RESET, 24'h0});
    check_value("slave_rx", slave_received, 8'h42);
    run_transfer(8'hB4, 8'h1D, rx);
    check_value("rx_byte_next", rx, 8'h1D);
  endtask

  initial begin
    logic [7:0] rx;
    clk         = 1'b0;
    rst_n       = 1'b0;
    wp_n        = 1'b1;
    be          = 4'h0;
    data_in     = '0;
    read        = 1'b0;
    write       = 1'b0;
    address     = REG_DATA;
    slave_cpol  = 1'b0;
    slave_cpha  = 1'b0;
    slave_reply = 8'h00;
    error_count = 0;
    check_count = 0;
    rng_state   = 32'hf153;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    idle_cycle();
    test_reset_values();
    test_byte_enables();
    set_mode(1'b0, 1'b0);
    run_transfer(8'hA5, 8'h3C, rx);  // Mode 0 byte
    check_value("rx_byte", rx, 8'h3C);
    test_all_modes();
    test_write_while_busy();
    test_release_and_idle();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
